//--- verilog.f
imuldiv_cfg_pkg.sv
imuldiv_msg_pkg.sv
imuldiv_sign_unpack.sv
imuldiv_stage_reg.sv
imuldiv_iter_ctrl.sv
imuldiv_iter_dpath.sv
imuldiv_sign_fix.sv
imuldiv_top.sv
tb_imuldiv.sv

//--- run.sh
#!/bin/sh
# build the mul/div testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -Wno-fatal --top-module tb_imuldiv \
  -f verilog.f -o tb_imuldiv

out=$(./obj_dir/tb_imuldiv)
echo "$out"

if echo "$out" | grep -qx "Test completed successfully"; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- tb_imuldiv.sv
// testbench for imuldiv_top; expected values use native 64-bit arithmetic
// scoreboard updates on the falling edge, so checks on the rising edge see settled state
// the idle latency check only holds with resp_rdy high and the unit drained
`timescale 1ns/1ps
`default_nettype none

module tb_imuldiv;

  localparam int dw = imuldiv_cfg_pkg::data_w;
  localparam int rw = imuldiv_cfg_pkg::result_w;
  localparam int fw = imuldiv_msg_pkg::func_w;

  // bound on every wait, in cycles
  localparam int wait_limit   = 2000;
  localparam int idle_latency = 35;
  localparam int random_count = 400;
  localparam int corner_count = 7;

  // one outstanding request and its expected response
  typedef struct packed {
    logic [fw-1:0] func;
    logic [dw-1:0] a;
    logic [dw-1:0] b;
    logic [rw-1:0] result;
  } exp_t;

  logic          clk = 1'b0;
  logic          reset;
  logic [fw-1:0] req_func;
  logic [dw-1:0] req_a;
  logic [dw-1:0] req_b;
  logic          req_val;
  logic          req_rdy;
  logic [rw-1:0] resp_result;
  logic          resp_val;
  logic          resp_rdy = 1'b1;

  integer      seed = 32'h474;
  integer      rdy_seed = 32'h474;
  logic [31:0] rdy_draw;
  bit          bp_enable = 1'b0;
  bit          lat_mode = 1'b0;

  // scoreboard state
  exp_t exp_q[$];
  exp_t exp_head = '0;
  int   exp_count = 0;
  exp_t pend_entry;
  bit   pend_push = 1'b0;
  bit   pend_pop = 1'b0;
  bit   lat_armed = 1'b0;
  int   lat_cycles = 0;

  int value_errors = 0;
  int protocol_errors = 0;
  int timeout_errors = 0;

  imuldiv_top dut0 (
    .clk         (clk),
    .reset       (reset),
    .req_func    (req_func),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  // 4 ns period
  always #2 clk = ~clk;

  // consumer is ready about three cycles in four under back-pressure
  always @(posedge clk) begin
    rdy_draw = $random(rdy_seed);
    if (bp_enable) begin
      resp_rdy <= (rdy_draw[1:0] != 2'd0);
    end else begin
      resp_rdy <= 1'b1;
    end
  end

  // ------------------------------
  // reference model
  // ------------------------------

  function automatic logic [rw-1:0] model_result(input logic [fw-1:0] func,
                                                 input logic [dw-1:0] a,
                                                 input logic [dw-1:0] b);
    longint      sa;
    longint      sb;
    longint      q;
    longint      r;
    logic [63:0] ua;
    logic [63:0] ub;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    ua = {32'd0, a};
    ub = {32'd0, b};
    case (func)
      imuldiv_msg_pkg::FUNC_MUL: model_result = 64'(sa * sb);
      imuldiv_msg_pkg::FUNC_MULU: model_result = ua * ub;
      default: begin
        if (b == '0) begin
          // zero divisor gives an all ones quotient and the dividend as remainder
          model_result = {a, {dw{1'b1}}};
        end else if (func == imuldiv_msg_pkg::FUNC_DIV) begin
          // 64-bit math keeps min / -1 from overflowing; C-style truncation
          q = sa / sb;
          r = sa % sb;
          model_result = {r[dw-1:0], q[dw-1:0]};
        end else begin
          model_result = {32'(ua % ub), 32'(ua / ub)};
        end
      end
    endcase
  endfunction

  function automatic string func_name(input logic [fw-1:0] func);
    case (func)
      imuldiv_msg_pkg::FUNC_MUL: return "signed multiply";
      imuldiv_msg_pkg::FUNC_MULU: return "unsigned multiply";
      imuldiv_msg_pkg::FUNC_DIV: return "signed divide";
      default: return "unsigned divide";
    endcase
  endfunction

  // zero, one, minus one, most negative, most positive and two small values
  function automatic logic [dw-1:0] corner_value(input int idx);
    case (idx)
      0: return 32'h0000_0000;
      1: return 32'h0000_0001;
      2: return 32'hffff_ffff;
      3: return 32'h8000_0000;
      4: return 32'h7fff_ffff;
      5: return 32'h0000_0003;
      default: return 32'hffff_fff9;
    endcase
  endfunction

  // quarter corners, quarter small signed values, half full range
  function automatic logic [dw-1:0] pick_operand();
    logic [31:0] sel;
    sel = $random(seed);
    case (sel[1:0])
      2'd0: return corner_value(int'(sel[10:8]) % corner_count);
      2'd1: return dw'($signed(sel[7:3]));
      default: return $random(seed);
    endcase
  endfunction

  // ------------------------------
  // scoreboard
  // ------------------------------

  // transfers flagged on one falling edge took place on the rising edge that followed
  always @(negedge clk) begin
    if (reset) begin
      exp_q.delete();
      pend_push = 1'b0;
      pend_pop = 1'b0;
      lat_armed = 1'b0;
      lat_cycles = 0;
    end else begin
      // cycles from the request transfer up to the response transfer
      if (lat_armed) begin
        if (pend_pop) begin
          lat_armed = 1'b0;
        end else begin
          lat_cycles++;
        end
      end
      if (pend_pop && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
      end
      if (pend_push) begin
        exp_q.push_back(pend_entry);
      end
      // inputs only move on the rising edge, so these predict the next transfer
      pend_pop = resp_val && resp_rdy;
      pend_push = req_val && req_rdy;
      pend_entry.func = req_func;
      pend_entry.a = req_a;
      pend_entry.b = req_b;
      pend_entry.result = model_result(req_func, req_a, req_b);
      if (lat_mode && req_val && req_rdy) begin
        lat_armed = 1'b1;
        lat_cycles = 0;
      end
    end
    exp_count = exp_q.size();
    if (exp_count != 0) begin
      exp_head = exp_q[0];
    end else begin
      exp_head = '0;
    end
  end

  // ------------------------------
  // checks
  // ------------------------------

  a_resp_value : assert property (@(posedge clk) disable iff (reset)
    (resp_val && resp_rdy && exp_count != 0) |-> (resp_result == exp_head.result))
    else begin
      value_errors++;
      $display("ERROR %s a=%h b=%h: expected %h, actual %h", func_name(exp_head.func),
               exp_head.a, exp_head.b, exp_head.result, $sampled(resp_result));
    end

  // a response with nothing outstanding is a duplicate or a spurious one
  a_resp_pending : assert property (@(posedge clk) disable iff (reset)
    (resp_val && resp_rdy) |-> (exp_count != 0))
    else begin
      protocol_errors++;
      $display("a response arrived while no request was outstanding");
    end

  a_resp_hold : assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_result)))
    else begin
      protocol_errors++;
      $display("the response dropped or changed while the consumer stalled it");
    end

  a_idle_latency : assert property (@(posedge clk) disable iff (reset)
    (lat_armed && resp_val) |-> (lat_cycles == idle_latency))
    else begin
      value_errors++;
      $display("ERROR idle latency: expected %0d, actual %0d", idle_latency,
               $sampled(lat_cycles));
    end

  // ------------------------------
  // stimulus
  // ------------------------------

  // called and returns on a rising edge
  task automatic send_request(input logic [fw-1:0] func, input logic [dw-1:0] a,
                              input logic [dw-1:0] b);
    int waited;
    bit accepted;
    waited = 0;
    req_func <= func;
    req_a <= a;
    req_b <= b;
    req_val <= 1'b1;
    @(negedge clk);
    while (!req_rdy && waited < wait_limit) begin
      @(negedge clk);
      waited++;
    end
    accepted = req_rdy;
    @(posedge clk);
    if (!accepted) begin
      timeout_errors++;
      $display("a %s request was not accepted within %0d cycles", func_name(func),
               wait_limit);
    end
    req_val <= 1'b0;
  endtask

  // wait until every accepted request has been answered
  task automatic wait_drain();
    int waited;
    waited = 0;
    @(posedge clk);
    while ((exp_count != 0 || pend_push) && waited < wait_limit) begin
      @(posedge clk);
      waited++;
    end
    if (exp_count != 0 || pend_push) begin
      timeout_errors++;
      $display("%0d responses were still missing after %0d cycles", exp_count, wait_limit);
    end
  endtask

  initial begin
    logic [fw-1:0] op_func;
    logic [dw-1:0] op_a;
    logic [dw-1:0] op_b;
    reset = 1'b1;
    req_val = 1'b0;
    req_func = '0;
    req_a = '0;
    req_b = '0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    // single requests on an idle unit with resp_rdy held high
    lat_mode <= 1'b1;
    send_request(imuldiv_msg_pkg::FUNC_MUL, 32'hffff_fffd, 32'd9);
    wait_drain();
    send_request(imuldiv_msg_pkg::FUNC_DIV, 32'hffff_ff9c, 32'd7);
    wait_drain();
    lat_mode <= 1'b0;

    // every pair of corner values for every function, under back-pressure
    bp_enable <= 1'b1;
    for (int f = 0; f < 4; f++) begin
      for (int i = 0; i < corner_count; i++) begin
        for (int j = 0; j < corner_count; j++) begin
          send_request(fw'(f), corner_value(i), corner_value(j));
        end
      end
    end

    // random mix
    for (int n = 0; n < random_count; n++) begin
      op_func = fw'($random(seed));
      op_a = pick_operand();
      op_b = pick_operand();
      send_request(op_func, op_a, op_b);
    end
    wait_drain();

    $display("errors: %0d value, %0d protocol, %0d timeout", value_errors,
             protocol_errors, timeout_errors);
    if (value_errors + protocol_errors + timeout_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- imuldiv_top.sv
// request to response chain of the iterative mul/div unit
// up to three operations in flight and 35 cycles idle latency
`timescale 1ns/1ps
`default_nettype none

module imuldiv_top (
  input  wire logic                                 clk,
  input  wire logic                                 reset,

  input  wire logic [imuldiv_msg_pkg::func_w-1:0]   req_func,
  input  wire logic [imuldiv_cfg_pkg::data_w-1:0]   req_a,
  input  wire logic [imuldiv_cfg_pkg::data_w-1:0]   req_b,
  input  wire logic                                 req_val,
  output logic                                      req_rdy,

  output logic [imuldiv_cfg_pkg::result_w-1:0]      resp_result,
  output logic                                      resp_val,
  input  wire logic                                 resp_rdy
);

  imuldiv_msg_pkg::op_t  unpacked_op;
  imuldiv_msg_pkg::op_t  eng_op;
  imuldiv_msg_pkg::res_t eng_res;
  logic [imuldiv_cfg_pkg::result_w-1:0] fixed_result;

  logic eng_req_val;
  logic eng_req_rdy;
  logic eng_resp_val;
  logic eng_resp_rdy;
  logic eng_load;
  logic eng_step;

  // ------------------------------
  // front end
  // ------------------------------

  imuldiv_sign_unpack unpack (
    .func (req_func),
    .a    (req_a),
    .b    (req_b),
    .op   (unpacked_op)
  );

  imuldiv_stage_reg #(
    .payload_t (imuldiv_msg_pkg::op_t)
  ) op_reg (
    .clk      (clk),
    .reset    (reset),
    .in_val   (req_val),
    .in_rdy   (req_rdy),
    .in_data  (unpacked_op),
    .out_val  (eng_req_val),
    .out_rdy  (eng_req_rdy),
    .out_data (eng_op)
  );

  // ------------------------------
  // iterative engine
  // ------------------------------

  imuldiv_iter_ctrl ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (eng_req_val),
    .req_rdy  (eng_req_rdy),
    .resp_val (eng_resp_val),
    .resp_rdy (eng_resp_rdy),
    .load     (eng_load),
    .step     (eng_step)
  );

  imuldiv_iter_dpath dpath (
    .clk   (clk),
    .reset (reset),
    .load  (eng_load),
    .step  (eng_step),
    .op    (eng_op),
    .res   (eng_res)
  );

  // ------------------------------
  // back end
  // ------------------------------

  imuldiv_sign_fix fix (
    .res    (eng_res),
    .result (fixed_result)
  );

  imuldiv_stage_reg #(
    .payload_t (logic [imuldiv_cfg_pkg::result_w-1:0])
  ) res_reg (
    .clk      (clk),
    .reset    (reset),
    .in_val   (eng_resp_val),
    .in_rdy   (eng_resp_rdy),
    .in_data  (fixed_result),
    .out_val  (resp_val),
    .out_rdy  (resp_rdy),
    .out_data (resp_result)
  );

endmodule

`default_nettype wire

//--- imuldiv_sign_fix.sv
// combinational sign restore on the engine's magnitude result
// zero divisor gives an all ones quotient and the raw dividend as remainder
`timescale 1ns/1ps
`default_nettype none

module imuldiv_sign_fix (
  input  imuldiv_msg_pkg::res_t                   res,
  output logic [imuldiv_cfg_pkg::result_w-1:0]    result
);

  localparam int dw = imuldiv_cfg_pkg::data_w;

  logic [imuldiv_cfg_pkg::result_w-1:0] mul_res;
  logic [dw-1:0] quot;
  logic [dw-1:0] rem;

  // ------------------------------
  // multiply
  // ------------------------------

  // the whole product is negated as one value
  assign mul_res = res.neg_lo ? (~res.raw + 1'b1) : res.raw;

  // ------------------------------
  // divide
  // ------------------------------

  // each half carries its own sign
  assign quot = res.neg_lo ? (~res.raw[dw-1:0] + 1'b1) : res.raw[dw-1:0];
  assign rem  = res.neg_hi ? (~res.raw[2*dw-1:dw] + 1'b1) : res.raw[2*dw-1:dw];

  // ------------------------------
  // select
  // ------------------------------

  always_comb begin
    if (!res.is_div) begin
      result = mul_res;
    end else if (res.div_zero) begin
      // quotient saturates, remainder is the untouched dividend
      result = {res.dividend, {dw{1'b1}}};
    end else begin
      result = {rem, quot};
    end
  end

endmodule

`default_nettype wire

//--- imuldiv_iter_dpath.sv
// shift-add multiply and restoring divide sharing one set of registers
// operands are magnitudes; signs are restored downstream
// raw is only meaningful once the controller reaches done
`timescale 1ns/1ps
`default_nettype none

module imuldiv_iter_dpath (
  input  wire logic           clk,
  input  wire logic           reset,

  input  wire logic           load,
  input  wire logic           step,

  input  imuldiv_msg_pkg::op_t op,
  output imuldiv_msg_pkg::res_t res
);

  localparam int dw = imuldiv_cfg_pkg::data_w;
  localparam int rw = imuldiv_cfg_pkg::result_w;

  // side flags carried alongside the operation
  logic          is_div_q;
  logic          neg_lo_q;
  logic          neg_hi_q;
  logic          div_zero_q;
  logic [dw-1:0] dividend_q;

  // multiply uses a as the shifting multiplicand
  // divide uses a as the divisor sitting in the upper half
  logic [rw-1:0] a_q;
  // multiplier, shifted right each step
  logic [dw-1:0] b_q;
  // product accumulator, or the remainder/quotient pair
  logic [rw-1:0] acc_q;

  logic [rw-1:0] mul_acc;
  logic [rw:0]   div_shift;
  logic [rw:0]   div_diff;
  logic [rw-1:0] div_acc;

  // ------------------------------
  // step arithmetic
  // ------------------------------

  always_comb begin
    // add the multiplicand when the current multiplier bit is set
    mul_acc = b_q[0] ? (acc_q + a_q) : acc_q;

    // one extra bit so a borrow shows up as a negative difference
    div_shift = {acc_q, 1'b0};
    div_diff  = div_shift - {1'b0, a_q};

    // keep the difference and set the quotient bit when it did not go negative
    if (!div_diff[rw]) begin
      div_acc = {div_diff[rw-1:1], 1'b1};
    end else begin
      div_acc = div_shift[rw-1:0];
    end
  end

  // ------------------------------
  // flag registers
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      is_div_q   <= 1'b0;
      neg_lo_q   <= 1'b0;
      neg_hi_q   <= 1'b0;
      div_zero_q <= 1'b0;
    end else if (load) begin
      is_div_q   <= op.is_div;
      neg_lo_q   <= op.neg_lo;
      neg_hi_q   <= op.neg_hi;
      div_zero_q <= op.div_zero;
    end
  end

  // ------------------------------
  // operand and accumulator registers
  // ------------------------------

  always_ff @(posedge clk) begin
    if (load) begin
      dividend_q <= op.dividend;
      b_q        <= op.b_mag;
      if (op.is_div) begin
        // divisor aligned to the remainder half
        a_q   <= {op.b_mag, {dw{1'b0}}};
        acc_q <= {{dw{1'b0}}, op.a_mag};
      end else begin
        a_q   <= {{dw{1'b0}}, op.a_mag};
        acc_q <= '0;
      end
    end else if (step) begin
      if (is_div_q) begin
        acc_q <= div_acc;
      end else begin
        acc_q <= mul_acc;
        a_q   <= a_q << 1;
        b_q   <= b_q >> 1;
      end
    end
  end

  // ------------------------------
  // result
  // ------------------------------

  always_comb begin
    res.is_div   = is_div_q;
    res.neg_lo   = neg_lo_q;
    res.neg_hi   = neg_hi_q;
    res.div_zero = div_zero_q;
    res.dividend = dividend_q;
    res.raw      = acc_q;
  end

endmodule

`default_nettype wire

//--- imuldiv_iter_ctrl.sv
// sequencing for the shared iterative engine, one operation at a time
// a new request is only taken back in idle after the response leaves
`timescale 1ns/1ps
`default_nettype none

module imuldiv_iter_ctrl (
  input  wire logic clk,
  input  wire logic reset,

  input  wire logic req_val,
  output logic      req_rdy,

  output logic      resp_val,
  input  wire logic resp_rdy,

  output logic      load,
  output logic      step
);

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } state_t;

  state_t state_q;
  logic [imuldiv_cfg_pkg::count_w-1:0] count_q;
  logic last_step;

  // final calc cycle
  assign last_step = (count_q == imuldiv_cfg_pkg::count_w'(imuldiv_cfg_pkg::iter_count - 1));

  // ------------------------------
  // state and step counter
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= st_idle;
      count_q <= '0;
    end else begin
      case (state_q)
        st_idle: begin
          if (req_val && req_rdy) begin
            state_q <= st_calc;
            count_q <= '0;
          end
        end
        st_calc: begin
          if (last_step) begin
            state_q <= st_done;
          end else begin
            count_q <= count_q + 1'b1;
          end
        end
        st_done: begin
          // hold the result until the next stage takes it
          if (resp_val && resp_rdy) begin
            state_q <= st_idle;
            count_q <= '0;
          end
        end
        default: begin
          state_q <= st_idle;
        end
      endcase
    end
  end

  // ------------------------------
  // outputs
  // ------------------------------

  assign req_rdy  = (state_q == st_idle);
  assign resp_val = (state_q == st_done);
  assign load     = req_val && req_rdy;
  assign step     = (state_q == st_calc);

  // the engine reopens only after its result was handed on
  a_rdy_idle_only : assert property (@(posedge clk) disable iff (reset)
    $rose(req_rdy) |-> $past(resp_val && resp_rdy));

  // a loaded operation is presented one load cycle plus iter_count steps later
  a_fixed_latency : assert property (@(posedge clk) disable iff (reset)
    load |-> ##(imuldiv_cfg_pkg::iter_count + 1) resp_val);

endmodule

`default_nettype wire

//--- imuldiv_stage_reg.sv
// single entry valid/ready buffer, full throughput when the consumer is ready
// in_rdy depends combinationally on out_rdy
`timescale 1ns/1ps
`default_nettype none

module imuldiv_stage_reg #(
  parameter type payload_t = logic
) (
  input  wire logic clk,
  input  wire logic reset,

  input  wire logic in_val,
  output logic      in_rdy,
  input  payload_t  in_data,

  output logic      out_val,
  input  wire logic out_rdy,
  output payload_t  out_data
);

  logic     full_q;
  payload_t data_q;

  // accept when empty, or when the held item leaves this same cycle
  assign in_rdy   = !full_q || out_rdy;
  assign out_val  = full_q;
  assign out_data = data_q;

  // occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      full_q <= 1'b0;
    end else if (in_val && in_rdy) begin
      full_q <= 1'b1;
    end else if (out_rdy) begin
      full_q <= 1'b0;
    end
  end

  // payload only moves on an accepted transfer
  always_ff @(posedge clk) begin
    if (in_val && in_rdy) begin
      data_q <= in_data;
    end
  end

  // a stalled output holds both valid and data until taken
  a_stall_hold : assert property (@(posedge clk) disable iff (reset)
    (out_val && !out_rdy) |=> (out_val && $stable(out_data)));

endmodule

`default_nettype wire

//--- imuldiv_sign_unpack.sv
// purely combinational front end of the unit
// magnitudes of the most negative value come out as 2^(data_w-1) unsigned
`timescale 1ns/1ps
`default_nettype none

module imuldiv_sign_unpack (
  input  wire logic [imuldiv_msg_pkg::func_w-1:0] func,
  input  wire logic [imuldiv_cfg_pkg::data_w-1:0] a,
  input  wire logic [imuldiv_cfg_pkg::data_w-1:0] b,
  output imuldiv_msg_pkg::op_t                    op
);

  logic is_div;
  logic is_signed;
  logic a_neg;
  logic b_neg;

  // ------------------------------
  // function decode
  // ------------------------------

  assign is_div = (func == imuldiv_msg_pkg::FUNC_DIV) ||
                  (func == imuldiv_msg_pkg::FUNC_DIVU);

  assign is_signed = (func == imuldiv_msg_pkg::FUNC_MUL) ||
                     (func == imuldiv_msg_pkg::FUNC_DIV);

  // sign bits only count for the signed functions
  assign a_neg = is_signed && a[imuldiv_cfg_pkg::data_w-1];
  assign b_neg = is_signed && b[imuldiv_cfg_pkg::data_w-1];

  // ------------------------------
  // payload
  // ------------------------------

  always_comb begin
    op.is_div   = is_div;
    // product and quotient are negative when exactly one operand is
    op.neg_lo   = a_neg ^ b_neg;
    // remainder follows the dividend
    op.neg_hi   = is_div && a_neg;
    op.div_zero = is_div && (b == '0);

    // two's complement magnitudes
    op.a_mag    = a_neg ? (~a + 1'b1) : a;
    op.b_mag    = b_neg ? (~b + 1'b1) : b;

    op.dividend = a;
  end

endmodule

`default_nettype wire

//--- imuldiv_msg_pkg.sv
// function codes and the payloads passed between pipeline stages
// field widths come from imuldiv_cfg_pkg
`default_nettype none

package imuldiv_msg_pkg;

  // ------------------------------
  // function codes
  // ------------------------------

  localparam int func_w = 2;

  localparam logic [func_w-1:0] FUNC_MUL  = 2'd0;
  localparam logic [func_w-1:0] FUNC_MULU = 2'd1;
  localparam logic [func_w-1:0] FUNC_DIV  = 2'd2;
  localparam logic [func_w-1:0] FUNC_DIVU = 2'd3;

  // ------------------------------
  // stage payloads
  // ------------------------------

  // unpack stage to iterative engine
  typedef struct packed {
    logic                                  is_div;
    // negate product, or negate quotient
    logic                                  neg_lo;
    // negate remainder, division only
    logic                                  neg_hi;
    logic                                  div_zero;
    logic [imuldiv_cfg_pkg::data_w-1:0]    a_mag;
    logic [imuldiv_cfg_pkg::data_w-1:0]    b_mag;
    // raw dividend for the zero divisor rule
    logic [imuldiv_cfg_pkg::data_w-1:0]    dividend;
  } op_t;

  // iterative engine to sign fix stage
  typedef struct packed {
    logic                                  is_div;
    logic                                  neg_lo;
    logic                                  neg_hi;
    logic                                  div_zero;
    logic [imuldiv_cfg_pkg::data_w-1:0]    dividend;
    logic [imuldiv_cfg_pkg::result_w-1:0]  raw;
  } res_t;

endpackage

`default_nettype wire

//--- imuldiv_cfg_pkg.sv
// arithmetic sizing for the iterative mul/div unit
// iter_count must equal data_w since each step retires one operand bit
`default_nettype none

package imuldiv_cfg_pkg;

  // ------------------------------
  // operand and result widths
  // ------------------------------

  // width of each request operand
  localparam int data_w = 32;

  // product, or remainder in the upper half and quotient in the lower half
  localparam int result_w = 2 * data_w;

  // ------------------------------
  // iteration
  // ------------------------------

  // one step per operand bit, for both multiply and divide
  localparam int iter_count = data_w;

  // step counter runs 0 .. iter_count-1
  localparam int count_w = $clog2(iter_count);

endpackage

`default_nettype wire
